//--- adc_ctrl_patterns.txt
// Words 0 to 7 hold the 16-bit sample value of channels 0 to 7
// Each test is a header word then its command words then its expected data words
// Header bytes 3 to 0 hold mode, command count, data word count and err
// Modes are 0 plain, 1 trigger pulses, 2 cancel, 3 stray trigger, 4 data buffer full
00001A2B
00003C4D
00005E6F
00007081
000092A3
0000B4C5
0000D6E7
0000F809
// Eight channel read with delay 400
00010400 40000190 3C4D1A2B 70815E6F B4C592A3 F809D6E7
// Single reads of channel 5 then channel 2
00020200 60000005 60000002 0000B4C5 00005E6F
// No-op on three triggers then eight channel read
01020400 18000003 40000190 3C4D1A2B 70815E6F B4C592A3 F809D6E7
// Trigger wait cancelled then single read of channel 3
02030100 10000005 E0000000 60000003 00007081
// Opcode 5 gives bad_cmd
00010004 A0000000
// No-op with cont and nothing behind it gives cmd_underflow
00010002 0800000A
// Eight channel read with delay 1 gives delay_too_short
00010008 40000001
// Trigger with no wait pending gives unexp_trig
03000010
// Eight channel read into a full data buffer gives data_overflow
04010001 40000190
// End marker
FFFFFFFF

//--- filelist.f
adc_ctrl_pkg.sv
adc_cmd_sequencer.sv
adc_spi_frame_engine.sv
adc_sample_packer.sv
adc_ctrl_top.sv
tb_adc_spi_model.sv
tb_adc_ctrl.sv

//--- tb_adc_ctrl.sv
`timescale 1ns/1ps

module tb_adc_ctrl
  import adc_ctrl_pkg::*;
();

  localparam int CS_HIGH   = 8;
  localparam int FRAME_CYC = CS_HIGH + 17;  // High gap, 16 low cycles, done
  localparam int SETTLE    = 48;            // Quiet cycles watched after each test

  logic         clk;
  logic         resetn;
  logic         cmd_rd_en;
  adc_cmd_t     cmd_word;
  logic         cmd_empty;
  logic         data_wr_en;
  logic [31:0]  data_word;
  logic         data_full;
  logic         trigger;
  logic         waiting_for_trig;
  adc_err_t     err;
  logic         n_cs;
  logic         mosi;
  logic         miso;
  logic [31:0]  pat_mem [0:255];            // Pattern file image
  logic [127:0] chan_table;
  adc_cmd_t     cmd_q[$];                   // Command buffer model
  logic [31:0]  data_q[$];                  // Captured data words
  string        test_names [0:8] = '{"read_all_long_delay", "two_single_reads",
                                     "trigger_wait_then_read", "cancel_trigger_wait",
                                     "bad_opcode", "cmd_underflow", "delay_too_short",
                                     "unexpected_trigger", "data_overflow"};
  string        cur_test = "startup";
  int           errors, tests_run, tests_failed;
  int           cycle_cnt, test_start, cycle_limit;

  adc_ctrl_top #(.CS_HIGH_CYCLES(CS_HIGH)) adc_ctrl_top_i (
    .clk(clk), .resetn(resetn), .cmd_rd_en(cmd_rd_en), .cmd_word(cmd_word),
    .cmd_empty(cmd_empty), .data_wr_en(data_wr_en), .data_word(data_word),
    .data_full(data_full), .trigger(trigger), .waiting_for_trig(waiting_for_trig),
    .err(err), .n_cs(n_cs), .mosi(mosi), .miso(miso)
  );

  tb_adc_spi_model adc_model_i (
    .clk(clk), .n_cs(n_cs), .mosi(mosi), .miso(miso), .chan_table(chan_table)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;                    // 40 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Timeout, command buffer and data capture
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt - test_start > cycle_limit) begin
      $display("Timeout: test %s did not finish within %0d cycles", cur_test, cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic drive_cmd_head();
    cmd_empty = (cmd_q.size() == 0);
    cmd_word  = cmd_empty ? '0 : cmd_q[0];  // Head word visible while not empty
  endtask

  always @(posedge clk) begin
    if (cmd_rd_en === 1'b1) begin
      #2;
      void'(cmd_q.pop_front());
      drive_cmd_head();
    end
  end

  always @(posedge clk) begin
    if (data_wr_en === 1'b1) begin
      data_q.push_back(data_word);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;                                     // Drive and sample off the edge
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", what, expected, actual);
      errors++;
    end
  endtask

  task automatic push_cmd(input logic [31:0] word);
    cmd_q.push_back(word);
    drive_cmd_head();
  endtask

  task automatic apply_reset();
    resetn    = 1'b0;
    trigger   = 1'b0;
    data_full = 1'b0;
    cmd_q.delete();
    drive_cmd_head();
    repeat (16) next_cycle();               // Errors halt the DUT until here
    resetn = 1'b1;
    data_q.delete();
  endtask

  task automatic pulse_trigger();
    trigger = 1'b1;
    next_cycle();
    trigger = 1'b0;
  endtask

  // Header is mode, command count, word count, err in bytes 3 to 0
  task automatic run_test(input int idx, inout int ptr);
    logic [31:0] hdr;
    logic [4:0]  err_exp;
    adc_cmd_t    cmd;
    int          mode, n_cmd, n_exp, cmd_base, exp_base;
    int          delay_sum, waited, cs_low, errs_before, gap, i;
    hdr         = pat_mem[ptr];
    mode        = hdr[31:24];
    n_cmd       = hdr[23:16];
    n_exp       = hdr[15:8];
    err_exp     = hdr[4:0];
    cmd_base    = ptr + 1;
    exp_base    = cmd_base + n_cmd;
    ptr         = exp_base + n_exp;
    cur_test    = test_names[idx];
    errs_before = errors;
    delay_sum   = 0;
    for (i = 0; i < n_cmd; i++) begin
      cmd = pat_mem[cmd_base + i];
      if (!cmd.trig && (cmd.opcode == OP_NOOP || cmd.opcode == OP_READ_ALL)) begin
        delay_sum += cmd.count;
      end
    end
    test_start  = cycle_cnt;
    cycle_limit = 4 * delay_sum + 30 * FRAME_CYC + 16;
    apply_reset();
    data_full = (mode == 4);                // Held full for the whole test
    if (mode == 1 || mode == 2) begin
      push_cmd(pat_mem[cmd_base]);          // Wait command alone first
      while (waiting_for_trig !== 1'b1) next_cycle();
      for (i = 1; i < n_cmd; i++) push_cmd(pat_mem[cmd_base + i]);
      if (mode == 1) begin
        for (i = 0; i < 3; i++) begin
          gap = 2 + $urandom % 12;          // Idle gap before each pulse
          repeat (gap) next_cycle();
          check_value($sformatf("%s wait before pulse %0d", cur_test, i), 1, waiting_for_trig);
          pulse_trigger();
          check_value($sformatf("%s wait after pulse %0d", cur_test, i), (i < 2),
                      waiting_for_trig);
        end
      end else begin
        next_cycle();                       // Cancel popped here
        check_value($sformatf("%s wait after cancel", cur_test), 0, waiting_for_trig);
      end
    end else begin
      for (i = 0; i < n_cmd; i++) push_cmd(pat_mem[cmd_base + i]);
      if (mode == 3) pulse_trigger();       // No wait pending
    end
    waited = 0;
    while (data_q.size() < n_exp || cmd_q.size() != 0 || waited < delay_sum
           || (err_exp != 0 && err == '0)) begin
      next_cycle();
      waited++;
    end
    cs_low = 0;
    repeat (SETTLE) begin
      next_cycle();
      if (n_cs !== 1'b1) cs_low++;
    end
    if (err_exp != 0) begin
      check_value($sformatf("%s n_cs low cycles after halt", cur_test), 0, cs_low);
    end
    if (data_q.size() < n_exp) begin
      $display("Test %s: only %0d of %0d data words arrived", cur_test, data_q.size(), n_exp);
      errors++;
    end else if (data_q.size() > n_exp) begin
      $display("Test %s: %0d data words arrived but %0d were expected", cur_test,
               data_q.size(), n_exp);
      errors++;
    end
    for (i = 0; i < n_exp && i < data_q.size(); i++) begin
      check_value($sformatf("%s word %0d", cur_test, i), pat_mem[exp_base + i], data_q[i]);
    end
    check_value($sformatf("%s err", cur_test), err_exp, err);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", cur_test, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          ptr;
    int          idx;
    resetn       = 1'b0;
    trigger      = 1'b0;
    data_full    = 1'b0;
    cmd_empty    = 1'b1;
    cmd_word     = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_cnt    = 0;
    test_start   = 0;
    cycle_limit  = 1000;
    void'($urandom(32'h754d));              // Seed once
    $readmemh("adc_ctrl_patterns.txt", pat_mem);
    for (idx = 0; idx < 8; idx++) chan_table[idx*16 +: 16] = pat_mem[idx][15:0];
    if (^pat_mem[8] === 1'bx) begin
      $display("Pattern file adc_ctrl_patterns.txt could not be read");
      errors++;
    end else begin
      ptr = 8;
      idx = 0;
      while (pat_mem[ptr] !== 32'hFFFF_FFFF && idx < 9) begin
        run_test(idx, ptr);
        idx++;
      end
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run == 9) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb_adc_spi_model.sv
`timescale 1ns/1ps

module tb_adc_spi_model (
  input  logic         clk,
  input  logic         n_cs,
  input  logic         mosi,
  output logic         miso,
  input  logic [127:0] chan_table  // Eight 16-bit channel values with channel 0 lowest
);

  logic [15:0] rx_word;   // Request bits seen on mosi
  logic [15:0] tx_word;   // Sample being returned
  logic [2:0]  req_chan;  // Channel of the last complete request

  initial begin
    miso     = 1'b0;
    rx_word  = '0;
    tx_word  = '0;
    req_chan = '0;
  end

  // Frame start
  // The previous request's value goes out during this frame
  always @(negedge n_cs) begin
    tx_word = chan_table[req_chan*16 +: 16];
    miso    = tx_word[15];                  // MSB first
  end

  // DUT samples miso and shifts mosi on the same edge
  always @(posedge clk) begin
    if (n_cs === 1'b0) begin
      rx_word = {rx_word[14:0], mosi};
      #2;                                   // Next bit shortly after the edge
      tx_word = {tx_word[14:0], 1'b0};
      miso    = tx_word[15];
    end
  end

  // Request word is prefix then channel then zeros
  always @(posedge n_cs) begin
    req_chan = rx_word[13:11];
  end

endmodule

//--- adc_ctrl_top.sv
`timescale 1ns/1ps

module adc_ctrl_top
  import adc_ctrl_pkg::*;
#(
  parameter int unsigned CS_HIGH_CYCLES = 8 // n_cs high cycles between frames
) (
  input  logic        clk,
  input  logic        resetn,
  // Command buffer
  output logic        cmd_rd_en,
  input  adc_cmd_t    cmd_word,
  input  logic        cmd_empty,
  // Data buffer
  output logic        data_wr_en,
  output logic [31:0] data_word,
  input  logic        data_full,
  // Status
  input  logic        trigger,
  output logic        waiting_for_trig,
  output adc_err_t    err,
  // ADC pins
  output logic        n_cs,
  output logic        mosi,
  input  logic        miso
);

  adc_frame_req_t frame_req;
  logic           frame_done;
  adc_sample_t    sample;
  logic           single_pending;
  logic           data_overflow;  // From packer
  logic           halted;         // Error state reached
  adc_err_t       err_seq;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  adc_cmd_sequencer adc_cmd_sequencer_i (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_word         (cmd_word),
    .cmd_empty        (cmd_empty),
    .cmd_rd_en        (cmd_rd_en),
    .trigger          (trigger),
    .waiting_for_trig (waiting_for_trig),
    .frame_req        (frame_req),
    .frame_done       (frame_done),
    .single_pending   (single_pending),
    .data_overflow    (data_overflow),
    .err_seq          (err_seq),
    .halted           (halted)
  );

  adc_spi_frame_engine #(
    .CS_HIGH_CYCLES (CS_HIGH_CYCLES)
  ) adc_spi_frame_engine_i (
    .clk        (clk),
    .resetn     (resetn),
    .halted     (halted),
    .frame_req  (frame_req),
    .frame_done (frame_done),
    .sample     (sample),
    .n_cs       (n_cs),
    .mosi       (mosi),
    .miso       (miso)
  );

  adc_sample_packer adc_sample_packer_i (
    .clk            (clk),
    .resetn         (resetn),
    .halted         (halted),
    .sample         (sample),
    .single_pending (single_pending),
    .data_wr_en     (data_wr_en),
    .data_word      (data_word),
    .data_full      (data_full),
    .data_overflow  (data_overflow)
  );

  // Sequencer flags plus packer overflow
  always_comb begin
    err               = err_seq;
    err.data_overflow = data_overflow;
  end

endmodule

//--- adc_sample_packer.sv
`timescale 1ns/1ps

module adc_sample_packer
  import adc_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        halted,
  input  adc_sample_t sample,
  input  logic        single_pending, // Mark for one single read sample
  output logic        data_wr_en,
  output logic [31:0] data_word,
  input  logic        data_full,
  output logic        data_overflow   // Sticky
);

  logic [1:0]  singles;     // Pending single reads
  logic        take_single;
  logic        held;        // Low half of a pair stored
  logic [15:0] held_data;
  logic        try_write;
  logic [31:0] word_next;

  assign take_single = sample.valid && (singles != 2'd0);
  assign try_write   = take_single || (sample.valid && held);

  // Single gets zero upper half
  // Pair puts the earlier sample low
  assign word_next = take_single ? {16'd0, sample.data} : {sample.data, held_data};

  ////////////////////////////////////////////////////////////////////////////
  // Single read bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      singles <= '0;
    end else if (single_pending && !take_single) begin
      if (singles != 2'd3) begin
        singles <= singles + 2'd1; // Saturate at 3
      end
    end else if (take_single && !single_pending) begin
      singles <= singles - 2'd1;
    end
  end

  // Alternate between holding and pairing
  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      held <= 1'b0;
    end else if (sample.valid && !take_single) begin
      held <= !held;
    end
  end

  always_ff @(posedge clk) begin
    if (sample.valid && !take_single && !held) begin
      held_data <= sample.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data buffer write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      data_wr_en <= 1'b0;
    end else begin
      data_wr_en <= try_write && !data_full; // Word is dropped when full
    end
  end

  always_ff @(posedge clk) begin
    if (try_write && !data_full) begin
      data_word <= word_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      data_overflow <= 1'b0;
    end else if (try_write && data_full && !halted) begin
      data_overflow <= 1'b1;
    end
  end

endmodule

//--- adc_spi_frame_engine.sv
`timescale 1ns/1ps

module adc_spi_frame_engine
  import adc_ctrl_pkg::*;
#(
  parameter int unsigned CS_HIGH_CYCLES = 8 // n_cs high gap before each frame
) (
  input  logic           clk,
  input  logic           resetn,
  input  logic           halted,
  input  adc_frame_req_t frame_req,
  output logic           frame_done,
  output adc_sample_t    sample,
  output logic           n_cs,
  output logic           mosi,
  input  logic           miso
);

  localparam int BIT_CNT_W = $clog2(SPI_FRAME_BITS);

  logic                      cs_wait;   // Counting the high gap
  logic                      shifting;  // n_cs low window
  logic [7:0]                cs_timer;
  logic [BIT_CNT_W-1:0]      bit_cnt;
  logic [SPI_FRAME_BITS-1:0] tx_shift;
  logic [SPI_FRAME_BITS-1:0] rx_shift;
  logic                      expect_q;  // Frame carries a sample back
  logic                      idle;
  logic                      accept;
  logic                      last_bit;
  logic                      sample_valid;
  logic [15:0]               sample_data;

  assign idle     = !cs_wait && !shifting;
  assign accept   = idle && frame_req.start;
  assign last_bit = shifting && (bit_cnt == '0);
  assign mosi     = tx_shift[SPI_FRAME_BITS-1]; // MSB first

  ////////////////////////////////////////////////////////////////////////////
  // Chip select and bit timing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      cs_wait  <= 1'b0;
      shifting <= 1'b0;
      cs_timer <= '0;
      bit_cnt  <= '0;
      n_cs     <= 1'b1;
    end else if (accept) begin
      cs_wait  <= 1'b1;
      cs_timer <= 8'(CS_HIGH_CYCLES - 1);
    end else if (cs_wait) begin
      if (cs_timer == '0) begin
        cs_wait  <= 1'b0;
        shifting <= 1'b1;
        n_cs     <= 1'b0;                         // Low for exactly 16 cycles
        bit_cnt  <= BIT_CNT_W'(SPI_FRAME_BITS - 1);
      end else begin
        cs_timer <= cs_timer - 8'd1;
      end
    end else if (shifting) begin
      if (last_bit) begin
        shifting <= 1'b0;
        n_cs     <= 1'b1; // Rises together with frame_done
      end else begin
        bit_cnt  <= bit_cnt - 1'b1;
      end
    end
  end

  // Transmit word
  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      tx_shift <= '0; // Keeps mosi quiet
    end else if (accept) begin
      tx_shift <= otf_request(frame_req.chan);
    end else if (shifting) begin
      tx_shift <= {tx_shift[SPI_FRAME_BITS-2:0], 1'b0};
    end
  end

  // Receive side and request flags
  always_ff @(posedge clk) begin
    if (accept) begin
      expect_q <= frame_req.expect_rx;
    end
    if (shifting) begin
      rx_shift <= {rx_shift[SPI_FRAME_BITS-2:0], miso}; // Sample miso each low cycle
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame completion and sample output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      frame_done   <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      frame_done   <= last_bit;
      sample_valid <= frame_done && expect_q; // Cycle after frame_done
    end
  end

  always_ff @(posedge clk) begin
    if (frame_done) begin
      sample_data <= rx_shift;
    end
  end

  assign sample = '{valid: sample_valid, data: sample_data};

endmodule

//--- adc_cmd_sequencer.sv
`timescale 1ns/1ps

module adc_cmd_sequencer
  import adc_ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           resetn,
  input  adc_cmd_t       cmd_word,         // Head of command buffer
  input  logic           cmd_empty,
  output logic           cmd_rd_en,        // Pop head word
  input  logic           trigger,
  output logic           waiting_for_trig,
  output adc_frame_req_t frame_req,
  input  logic           frame_done,
  output logic           single_pending,   // Next sample is a single read
  input  logic           data_overflow,    // Sticky flag from packer
  output adc_err_t       err_seq,
  output logic           halted
);

  adc_state_e  state;
  adc_state_e  next_cmd_state;  // Where the head command leads
  logic        cmd_ready;
  logic        cmd_done;
  logic        do_next_cmd;
  logic        cancel_wait;
  logic        is_read_op;
  logic        wait_trig;       // Latched trig bit of running command
  logic        expect_next;     // Latched cont bit
  logic [24:0] delay_timer;
  logic [24:0] trig_cnt;
  logic        delay_done;
  logic        trig_done;
  logic [3:0]  frame_idx;       // Frame number within a read
  logic [3:0]  next_idx;
  logic        last_frame;
  logic        read_done;
  adc_err_t    err_now;         // Error conditions this cycle
  logic        any_err;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and completion
  ////////////////////////////////////////////////////////////////////////////

  assign cmd_ready  = !cmd_empty;
  assign is_read_op = (cmd_word.opcode == OP_READ_ALL) || (cmd_word.opcode == OP_READ_ONE);
  assign delay_done = (delay_timer == '0);
  assign trig_done  = (trigger && trig_cnt == 25'd1) || (trig_cnt == '0); // Count 0 ends at once
  assign next_idx   = frame_idx + 4'd1;

  // Eight reads plus dummy frame or one read plus dummy
  assign last_frame = (state == ST_READ_ALL && frame_idx == 4'(ADC_CHANNELS))
                   || (state == ST_READ_ONE && frame_idx == 4'd1);
  assign read_done  = frame_done && last_frame;

  always_comb begin
    case (state)
      ST_IDLE:      cmd_done = cmd_ready;
      ST_DELAY:     cmd_done = delay_done;
      ST_TRIG_WAIT: cmd_done = trig_done;
      ST_READ_ALL:  cmd_done = read_done && (wait_trig ? trig_done : delay_done);
      ST_READ_ONE:  cmd_done = read_done;
      default:      cmd_done = 1'b0; // Halted
    endcase
  end

  assign do_next_cmd = cmd_done && cmd_ready;

  // Cancel only acts on a pending wait
  assign cancel_wait = cmd_ready && (cmd_word.opcode == OP_CANCEL)
                    && (state == ST_DELAY || state == ST_TRIG_WAIT
                        || (state == ST_READ_ALL && read_done));

  always_comb begin
    if (!cmd_ready) begin
      next_cmd_state = expect_next ? ST_ERROR : ST_IDLE; // Underflow when more was promised
    end else begin
      case (cmd_word.opcode)
        OP_NOOP:     next_cmd_state = cmd_word.trig ? ST_TRIG_WAIT : ST_DELAY;
        OP_READ_ALL: next_cmd_state = ST_READ_ALL;
        OP_READ_ONE: next_cmd_state = ST_READ_ONE;
        OP_CANCEL:   next_cmd_state = ST_IDLE;
        default:     next_cmd_state = ST_ERROR; // Bad opcode
      endcase
    end
  end

  assign cmd_rd_en        = !halted && cmd_ready && (cmd_done || cancel_wait);
  assign waiting_for_trig = (state == ST_TRIG_WAIT);
  assign halted           = (state == ST_ERROR);

  ////////////////////////////////////////////////////////////////////////////
  // Error detection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    err_now                 = '0; // Overflow bit stays zero here
    err_now.unexp_trig      = trigger && (state != ST_TRIG_WAIT) && (trig_cnt <= 25'd1);
    err_now.delay_too_short = (state == ST_READ_ALL) && !read_done && !wait_trig && delay_done;
    err_now.bad_cmd         = do_next_cmd && (next_cmd_state == ST_ERROR);
    err_now.cmd_underflow   = cmd_done && expect_next && !cmd_ready;
  end

  assign any_err = !halted && ((|err_now) || data_overflow);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      err_seq <= '0;
    end else if (!halted) begin
      err_seq <= err_seq | err_now; // Sticky until reset
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State and command registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_IDLE;
    end else if (any_err) begin
      state <= ST_ERROR;       // Stays here until reset
    end else if (cancel_wait) begin
      state <= ST_IDLE;
    end else if (cmd_done) begin
      state <= next_cmd_state;
    end else if (state == ST_READ_ALL && read_done) begin
      state <= wait_trig ? ST_TRIG_WAIT : ST_DELAY; // Remaining wait after reads
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (do_next_cmd) begin
      wait_trig   <= cmd_word.trig;
      expect_next <= cmd_word.cont && (cmd_word.opcode != OP_CANCEL);
    end else if (cancel_wait) begin
      expect_next <= 1'b0; // Cancel itself is the follow-up
    end
  end

  // Delay runs from the pop of the command
  always_ff @(posedge clk) begin
    if (!resetn || halted || cancel_wait) begin
      delay_timer <= '0;
    end else if (do_next_cmd && !cmd_word.trig
                 && (cmd_word.opcode == OP_NOOP || cmd_word.opcode == OP_READ_ALL)) begin
      delay_timer <= cmd_word.count;
    end else if (!delay_done) begin
      delay_timer <= delay_timer - 25'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || halted || cancel_wait) begin
      trig_cnt <= '0;
    end else if (do_next_cmd && cmd_word.trig
                 && (cmd_word.opcode == OP_NOOP || cmd_word.opcode == OP_READ_ALL)) begin
      trig_cnt <= cmd_word.count;
    end else if (trigger && trig_cnt != '0) begin
      trig_cnt <= trig_cnt - 25'd1; // One pulse consumed
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      frame_idx <= '0;
    end else if (do_next_cmd && is_read_op) begin
      frame_idx <= '0;
    end else if (frame_done && !last_frame) begin
      frame_idx <= next_idx;
    end
  end

  // New start only at command start or on frame_done
  always_comb begin
    frame_req = '0;
    if (do_next_cmd && is_read_op) begin
      frame_req.start     = 1'b1;
      frame_req.chan      = (cmd_word.opcode == OP_READ_ONE) ? cmd_word.count[2:0] : 3'd0;
      frame_req.expect_rx = 1'b0; // Nothing requested yet
    end else if (frame_done && !last_frame
                 && (state == ST_READ_ALL || state == ST_READ_ONE)) begin
      frame_req.start     = 1'b1;
      frame_req.chan      = (state == ST_READ_ALL) ? next_idx[2:0] : 3'd0; // Ninth wraps to 0
      frame_req.expect_rx = 1'b1;
    end
  end

  // Sample of the single read follows this frame_done
  assign single_pending = read_done && (state == ST_READ_ONE);

endmodule

//--- adc_ctrl_pkg.sv
package adc_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // SPI frame constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int          SPI_FRAME_BITS    = 16;    // Bits per n_cs low window
  localparam logic [1:0]  OTF_SAMPLE_PREFIX = 2'b10; // On-the-fly sample request code
  localparam int          ADC_CHANNELS      = 8;     // Channels in one full read

  ////////////////////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////////////////////

  // Recognized opcodes
  // Every other opcode value lands in the error state
  typedef enum logic [2:0] {
    OP_NOOP     = 3'd0, // Wait only
    OP_READ_ALL = 3'd2, // Channels 0 to 7 then wait
    OP_READ_ONE = 3'd3, // One channel
    OP_CANCEL   = 3'd7  // Ends a delay or trigger wait
  } adc_opcode_e;

  typedef struct packed {
    logic [2:0]  opcode; // Raw opcode bits
    logic        trig;   // Wait on trigger pulses instead of delay
    logic        cont;   // Another command must follow
    logic [1:0]  spare;
    logic [24:0] count;  // Delay cycles or trigger count
  } adc_cmd_t;

  // Sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DELAY,
    ST_TRIG_WAIT,
    ST_READ_ALL,
    ST_READ_ONE,
    ST_ERROR
  } adc_state_e;

  // Sticky error flags
  typedef struct packed {
    logic unexp_trig;
    logic delay_too_short;
    logic bad_cmd;
    logic cmd_underflow;
    logic data_overflow;
  } adc_err_t;

  ////////////////////////////////////////////////////////////////////////////
  // Internal transfer types
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       start;     // One cycle strobe
    logic [2:0] chan;      // Channel to request
    logic       expect_rx; // Frame returns the previous request's sample
  } adc_frame_req_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] data;
  } adc_sample_t;

  // Request word is prefix then channel then zero fill
  function automatic logic [SPI_FRAME_BITS-1:0] otf_request(input logic [2:0] chan);
    return {OTF_SAMPLE_PREFIX, chan, {(SPI_FRAME_BITS - 5){1'b0}}};
  endfunction

endpackage
